// File: verilog/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Start address after reset
`define FETCH_RESET_VECTOR 32'h0000_0000

// Number of one-word lines in the direct-mapped cache
`define FETCH_ICACHE_LINES 16

// Major opcodes in instruction bits [6:0]
`define FETCH_OP_LOAD     7'b0000011
`define FETCH_OP_LOAD_FP  7'b0000111
`define FETCH_OP_STORE    7'b0100011
`define FETCH_OP_STORE_FP 7'b0100111
`define FETCH_OP_OP       7'b0110011
`define FETCH_OP_OP_IMM   7'b0010011
`define FETCH_OP_OP_FP    7'b1010011
`define FETCH_OP_BRANCH   7'b1100011
`define FETCH_OP_JAL      7'b1101111
`define FETCH_OP_JALR     7'b1100111
`define FETCH_OP_LUI      7'b0110111
`define FETCH_OP_AUIPC    7'b0010111
`define FETCH_OP_SYSTEM   7'b1110011

// OP_FP funct7 values that move an operand to the integer file
`define FETCH_F7_FCMP     7'b1010000
`define FETCH_F7_FCVT_W_S 7'b1100000
`define FETCH_F7_FCVT_S_W 7'b1101000
`define FETCH_F7_FMV_X_W  7'b1110000
`define FETCH_F7_FMV_W_X  7'b1111000

// Full SYSTEM encodings that stop fetch
`define FETCH_INSN_ECALL 32'h0000_0073
`define FETCH_INSN_MRET  32'h3020_0073
`define FETCH_INSN_WFI   32'h1050_0073

`endif

// File: verilog/fetch_pkg.sv
`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

	// Instruction, address or bus data
	typedef logic [31:0] word_t;

	// Bundle sequence number that wraps around
	typedef logic [7:0] fetch_tag_t;

	// Bit 5 selects the FP register file
	typedef logic [5:0] reg_index_t;

	typedef logic [$clog2(`FETCH_ICACHE_LINES)-1:0] icache_index_t;

	typedef enum logic {
		FETCH_WAIT_ICACHE,
		FETCH_WAIT_JUMP
	} fetch_state_t;

endpackage

`default_nettype wire

// File: verilog/fetch_predecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_predecode (
	input wire fetch_pkg::word_t i_instruction,
	output fetch_pkg::reg_index_t o_rs1,
	output fetch_pkg::reg_index_t o_rs2,
	output fetch_pkg::reg_index_t o_rd,
	output logic o_control_flow
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	logic is_r;
	logic is_i;
	logic is_s;
	logic is_b;
	logic is_u;
	logic is_j;
	logic is_csr;

	logic is_op_fp;
	logic is_fmv_x_w;

	logic has_rs1;
	logic has_rs2;
	logic has_rd;
	logic rs1_fp;
	logic rs2_fp;
	logic rd_fp;

	assign opcode = i_instruction[6:0];
	assign funct3 = i_instruction[14:12];
	assign funct7 = i_instruction[31:25];

	// Format classes
	assign is_r = (opcode == `FETCH_OP_OP) || (opcode == `FETCH_OP_OP_FP);
	assign is_i = (opcode == `FETCH_OP_LOAD) || (opcode == `FETCH_OP_LOAD_FP) ||
		(opcode == `FETCH_OP_OP_IMM) || (opcode == `FETCH_OP_JALR);
	assign is_s = (opcode == `FETCH_OP_STORE) || (opcode == `FETCH_OP_STORE_FP);
	assign is_b = (opcode == `FETCH_OP_BRANCH);
	assign is_u = (opcode == `FETCH_OP_LUI) || (opcode == `FETCH_OP_AUIPC);
	assign is_j = (opcode == `FETCH_OP_JAL);
	// CSR access is SYSTEM with a nonzero funct3
	assign is_csr = (opcode == `FETCH_OP_SYSTEM) && (funct3 != 3'b000);

	assign has_rs1 = is_b || is_i || is_r || is_s || is_csr;
	assign has_rs2 = is_b || is_r || is_s;
	assign has_rd = is_i || is_j || is_r || is_u || is_csr;

	assign is_op_fp = (opcode == `FETCH_OP_OP_FP);
	assign is_fmv_x_w = is_op_fp && (funct7 == `FETCH_F7_FMV_X_W) && (funct3 == 3'b000);

	// Register file selection
	assign rs1_fp = is_op_fp && !is_fmv_x_w &&
		(funct7 != `FETCH_F7_FMV_W_X) && (funct7 != `FETCH_F7_FCVT_S_W);
	assign rs2_fp = is_op_fp || (opcode == `FETCH_OP_STORE_FP);
	assign rd_fp = (is_op_fp && !is_fmv_x_w &&
		(funct7 != `FETCH_F7_FCVT_W_S) && (funct7 != `FETCH_F7_FCMP)) ||
		(opcode == `FETCH_OP_LOAD_FP);

	assign o_rs1 = has_rs1 ? {rs1_fp, i_instruction[19:15]} : '0;
	assign o_rs2 = has_rs2 ? {rs2_fp, i_instruction[24:20]} : '0;
	assign o_rd = has_rd ? {rd_fp, i_instruction[11:7]} : '0;

	// Fetch stops here until decode sends a redirect
	assign o_control_flow = is_j || is_b || (opcode == `FETCH_OP_JALR) ||
		(i_instruction == `FETCH_INSN_ECALL) ||
		(i_instruction == `FETCH_INSN_MRET) ||
		(i_instruction == `FETCH_INSN_WFI);

endmodule

`default_nettype wire

// File: verilog/fetch_icache.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_icache (
	input wire i_clock,
	input wire i_reset,

	input wire fetch_pkg::word_t i_pc,
	input wire i_stall,
	output fetch_pkg::word_t o_rdata,
	output logic o_ready,

	output logic o_bus_request,
	output fetch_pkg::word_t o_bus_address,
	input wire i_bus_ready,
	input wire fetch_pkg::word_t i_bus_rdata
);
	import fetch_pkg::*;

	localparam int INDEX_BITS = $bits(icache_index_t);
	localparam int TAG_BITS = 30 - INDEX_BITS;

	logic [`FETCH_ICACHE_LINES-1:0] line_valid;
	logic [TAG_BITS-1:0] line_tag [`FETCH_ICACHE_LINES];
	word_t line_data [`FETCH_ICACHE_LINES];

	icache_index_t lookup_index;
	logic [TAG_BITS-1:0] lookup_tag;
	logic lookup_hit;
	logic lookup_enable;

	icache_index_t refill_index;
	logic [TAG_BITS-1:0] refill_tag;
	logic refill_active;

	logic ready_q;
	word_t ready_pc;

	assign lookup_index = i_pc[2 +: INDEX_BITS];
	assign lookup_tag = i_pc[31 -: TAG_BITS];
	assign lookup_hit = line_valid[lookup_index] && (line_tag[lookup_index] == lookup_tag);

	// One lookup per result; skip the cycle where a result is presented
	assign lookup_enable = !i_stall && !refill_active && !ready_q;

	assign refill_index = o_bus_address[2 +: INDEX_BITS];
	assign refill_tag = o_bus_address[31 -: TAG_BITS];

	assign o_bus_request = refill_active;

	// A PC redirect since the lookup drops the result
	assign o_ready = ready_q && (i_pc == ready_pc);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			line_valid <= '0;
			refill_active <= 1'b0;
			ready_q <= 1'b0;
		end else begin
			ready_q <= 1'b0;
			if (refill_active) begin
				if (i_bus_ready) begin
					line_valid[refill_index] <= 1'b1;
					refill_active <= 1'b0;
					// Stalled consumer picks the word up later as a hit
					ready_q <= !i_stall;
				end
			end else if (lookup_enable) begin
				if (lookup_hit) begin
					ready_q <= 1'b1;
				end else begin
					refill_active <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (refill_active && i_bus_ready) begin
			line_tag[refill_index] <= refill_tag;
			line_data[refill_index] <= i_bus_rdata;
			o_rdata <= i_bus_rdata;
			ready_pc <= o_bus_address;
		end else if (!refill_active && lookup_enable) begin
			o_rdata <= line_data[lookup_index];
			ready_pc <= i_pc;
			if (!lookup_hit) begin
				o_bus_address <= {i_pc[31:2], 2'b00};
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/fetch_hold_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_hold_buffer (
	input wire i_clock,
	input wire i_reset,
	input wire i_decode_busy,

	input wire fetch_pkg::fetch_tag_t i_tag,
	input wire fetch_pkg::word_t i_pc,
	input wire fetch_pkg::word_t i_instruction,
	input wire fetch_pkg::reg_index_t i_rs1,
	input wire fetch_pkg::reg_index_t i_rs2,
	input wire fetch_pkg::reg_index_t i_rs3,
	input wire fetch_pkg::reg_index_t i_rd,

	output fetch_pkg::fetch_tag_t o_tag,
	output fetch_pkg::word_t o_pc,
	output fetch_pkg::word_t o_instruction,
	output fetch_pkg::reg_index_t o_rs1,
	output fetch_pkg::reg_index_t o_rs2,
	output fetch_pkg::reg_index_t o_rs3,
	output fetch_pkg::reg_index_t o_rd
);
	import fetch_pkg::*;

	fetch_tag_t held_tag;
	word_t held_pc;
	word_t held_instruction;
	reg_index_t held_rs1;
	reg_index_t held_rs2;
	reg_index_t held_rs3;
	reg_index_t held_rd;

	// Copy of the bundle decode last accepted
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			held_tag <= '0;
			held_pc <= '0;
			held_instruction <= '0;
			held_rs1 <= '0;
			held_rs2 <= '0;
			held_rs3 <= '0;
			held_rd <= '0;
		end else if (!i_decode_busy) begin
			held_tag <= i_tag;
			held_pc <= i_pc;
			held_instruction <= i_instruction;
			held_rs1 <= i_rs1;
			held_rs2 <= i_rs2;
			held_rs3 <= i_rs3;
			held_rd <= i_rd;
		end
	end

	// Live bundle passes straight through while decode is free
	assign o_tag = i_decode_busy ? held_tag : i_tag;
	assign o_pc = i_decode_busy ? held_pc : i_pc;
	assign o_instruction = i_decode_busy ? held_instruction : i_instruction;
	assign o_rs1 = i_decode_busy ? held_rs1 : i_rs1;
	assign o_rs2 = i_decode_busy ? held_rs2 : i_rs2;
	assign o_rs3 = i_decode_busy ? held_rs3 : i_rs3;
	assign o_rd = i_decode_busy ? held_rd : i_rd;

endmodule

`default_nettype wire

// File: verilog/fetch_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_sequencer #(
	parameter fetch_pkg::word_t RESET_VECTOR = `FETCH_RESET_VECTOR
) (
	input wire i_clock,
	input wire i_reset,

	input wire i_jump,
	input wire fetch_pkg::word_t i_jump_pc,
	input wire i_irq_pending,
	input wire fetch_pkg::word_t i_irq_pc,
	output logic o_irq_dispatched,
	output fetch_pkg::word_t o_irq_epc,

	output logic o_bus_request,
	output fetch_pkg::word_t o_bus_address,
	input wire i_bus_ready,
	input wire fetch_pkg::word_t i_bus_rdata,

	input wire i_decode_busy,
	output fetch_pkg::fetch_tag_t o_tag,
	output fetch_pkg::word_t o_pc,
	output fetch_pkg::word_t o_instruction,
	output fetch_pkg::reg_index_t o_rs1,
	output fetch_pkg::reg_index_t o_rs2,
	output fetch_pkg::reg_index_t o_rs3,
	output fetch_pkg::reg_index_t o_rd
);
	import fetch_pkg::*;

	fetch_state_t state;
	word_t pc;

	word_t icache_rdata;
	logic icache_ready;
	logic icache_stall;

	reg_index_t pre_rs1;
	reg_index_t pre_rs2;
	reg_index_t pre_rd;
	logic pre_control_flow;

	// No three-source instructions are predecoded
	assign o_rs3 = '0;

	assign icache_stall = i_decode_busy || (state != FETCH_WAIT_ICACHE);

	fetch_icache icache0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(pc),
		.i_stall(icache_stall),
		.o_rdata(icache_rdata),
		.o_ready(icache_ready),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	fetch_predecode predecode0 (
		.i_instruction(icache_rdata),
		.o_rs1(pre_rs1),
		.o_rs2(pre_rs2),
		.o_rd(pre_rd),
		.o_control_flow(pre_control_flow)
	);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= FETCH_WAIT_ICACHE;
			pc <= RESET_VECTOR;
			o_irq_dispatched <= 1'b0;
			o_irq_epc <= '0;
			o_tag <= '0;
			o_pc <= '0;
			o_instruction <= '0;
			o_rs1 <= '0;
			o_rs2 <= '0;
			o_rd <= '0;
		end else begin
			o_irq_dispatched <= 1'b0;
			o_irq_epc <= '0;

			// Interrupt wins over fetch and redirect
			if (i_irq_pending) begin
				o_irq_dispatched <= 1'b1;
				o_irq_epc <= pc;
				pc <= i_irq_pc;
				state <= FETCH_WAIT_ICACHE;
			end else begin
				case (state)
					FETCH_WAIT_ICACHE: begin
						if (icache_ready) begin
							o_tag <= o_tag + 1'b1;
							o_pc <= pc;
							o_instruction <= icache_rdata;
							o_rs1 <= pre_rs1;
							o_rs2 <= pre_rs2;
							o_rd <= pre_rd;
							if (pre_control_flow) begin
								state <= FETCH_WAIT_JUMP;
							end else begin
								pc <= pc + 32'd4;
							end
						end
					end
					FETCH_WAIT_JUMP: begin
						if (i_jump) begin
							pc <= i_jump_pc;
							state <= FETCH_WAIT_ICACHE;
						end
					end
					default: begin
						state <= FETCH_WAIT_ICACHE;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_top #(
	parameter fetch_pkg::word_t RESET_VECTOR = `FETCH_RESET_VECTOR
) (
	input wire i_clock,
	input wire i_reset,

	input wire i_jump,
	input wire fetch_pkg::word_t i_jump_pc,
	input wire i_irq_pending,
	input wire fetch_pkg::word_t i_irq_pc,
	output logic o_irq_dispatched,
	output fetch_pkg::word_t o_irq_epc,

	output logic o_bus_request,
	output fetch_pkg::word_t o_bus_address,
	input wire i_bus_ready,
	input wire fetch_pkg::word_t i_bus_rdata,

	input wire i_decode_busy,
	output fetch_pkg::fetch_tag_t o_tag,
	output fetch_pkg::word_t o_pc,
	output fetch_pkg::word_t o_instruction,
	output fetch_pkg::reg_index_t o_rs1,
	output fetch_pkg::reg_index_t o_rs2,
	output fetch_pkg::reg_index_t o_rs3,
	output fetch_pkg::reg_index_t o_rd
);
	import fetch_pkg::*;

	// Sequencer bundle ahead of the back-pressure stage
	fetch_tag_t seq_tag;
	word_t seq_pc;
	word_t seq_instruction;
	reg_index_t seq_rs1;
	reg_index_t seq_rs2;
	reg_index_t seq_rs3;
	reg_index_t seq_rd;

	fetch_sequencer #(
		.RESET_VECTOR(RESET_VECTOR)
	) sequencer0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.i_decode_busy(i_decode_busy),
		.o_tag(seq_tag),
		.o_pc(seq_pc),
		.o_instruction(seq_instruction),
		.o_rs1(seq_rs1),
		.o_rs2(seq_rs2),
		.o_rs3(seq_rs3),
		.o_rd(seq_rd)
	);

	fetch_hold_buffer hold0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_decode_busy(i_decode_busy),
		.i_tag(seq_tag),
		.i_pc(seq_pc),
		.i_instruction(seq_instruction),
		.i_rs1(seq_rs1),
		.i_rs2(seq_rs2),
		.i_rs3(seq_rs3),
		.i_rd(seq_rd),
		.o_tag(o_tag),
		.o_pc(o_pc),
		.o_instruction(o_instruction),
		.o_rs1(o_rs1),
		.o_rs2(o_rs2),
		.o_rs3(o_rs3),
		.o_rd(o_rd)
	);

endmodule

`default_nettype wire

// File: testbench/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_tb;
	import fetch_pkg::*;

	localparam int BUNDLE_TIMEOUT = 60;

	logic i_clock;
	logic i_reset;
	logic i_jump;
	word_t i_jump_pc;
	logic i_irq_pending;
	word_t i_irq_pc;
	logic o_irq_dispatched;
	word_t o_irq_epc;
	logic o_bus_request;
	word_t o_bus_address;
	logic i_bus_ready;
	word_t i_bus_rdata;
	logic i_decode_busy;
	fetch_tag_t o_tag;
	word_t o_pc;
	word_t o_instruction;
	reg_index_t o_rs1;
	reg_index_t o_rs2;
	reg_index_t o_rs3;
	reg_index_t o_rd;

	// 1 KB of program memory
	word_t mem [0:255];
	integer seed;
	int bus_delay;
	logic bus_busy;
	int bus_request_count = 0;

	fetch_tag_t last_tag;
	word_t last_pc;

	fetch_top #(
		.RESET_VECTOR(`FETCH_RESET_VECTOR)
	) dut0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.i_decode_busy(i_decode_busy),
		.o_tag(o_tag),
		.o_pc(o_pc),
		.o_instruction(o_instruction),
		.o_rs1(o_rs1),
		.o_rs2(o_rs2),
		.o_rs3(o_rs3),
		.o_rd(o_rd)
	);

	initial begin
		i_clock = 1'b0;
		forever #50 i_clock = ~i_clock;
	end

	// Memory answers each request after 1 to 4 cycles
	always @(negedge i_clock) begin
		if (i_reset) begin
			bus_busy = 1'b0;
			bus_delay = 0;
			i_bus_ready = 1'b0;
		end else if (i_bus_ready) begin
			i_bus_ready = 1'b0;
			bus_busy = 1'b0;
		end else if (o_bus_request) begin
			if (!bus_busy) begin
				bus_busy = 1'b1;
				bus_delay = 1 + ({$random(seed)} % 4);
				bus_request_count++;
			end
			bus_delay = bus_delay - 1;
			if (bus_delay == 0) begin
				i_bus_ready = 1'b1;
				i_bus_rdata = mem[o_bus_address[9:2]];
			end
		end
	end

	task automatic abort_run;
		$display("FAIL: see errors above");
		$fatal(1, "stopping at first failure");
	endtask

	task automatic compare_word(input string what, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
			abort_run();
		end
	endtask

	task automatic compare_tag(input string what, input fetch_tag_t actual,
			input fetch_tag_t expected);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			abort_run();
		end
	endtask

	task automatic compare_index(input string what, input reg_index_t actual,
			input reg_index_t expected);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
			abort_run();
		end
	endtask

	task automatic compare_flag(input string what, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s is %b, expected %b", $time, what, actual, expected);
			abort_run();
		end
	endtask

	function automatic word_t encode_r(input logic [6:0] funct7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd,
			input logic [6:0] opcode);
		return {funct7, rs2, rs1, funct3, rd, opcode};
	endfunction

	function automatic word_t encode_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] funct3, input logic [4:0] rd, input logic [6:0] opcode);
		return {imm, rs1, funct3, rd, opcode};
	endfunction

	function automatic word_t encode_s(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] funct3, input logic [6:0] opcode);
		return {imm[11:5], rs2, rs1, funct3, imm[4:0], opcode};
	endfunction

	function automatic word_t encode_b(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] funct3);
		return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], `FETCH_OP_BRANCH};
	endfunction

	// Expected register indices by instruction format
	function automatic void predict_indices(input word_t insn, output reg_index_t rs1,
			output reg_index_t rs2, output reg_index_t rd);
		logic [6:0] opcode;
		logic [2:0] funct3;
		logic [6:0] funct7;
		logic fmv_x_w;
		logic use_rs1;
		logic use_rs2;
		logic use_rd;
		logic fp_rs1;
		logic fp_rs2;
		logic fp_rd;
		opcode = insn[6:0];
		funct3 = insn[14:12];
		funct7 = insn[31:25];
		fmv_x_w = (funct7 == `FETCH_F7_FMV_X_W) && (funct3 == 3'b000);
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		use_rd = 1'b0;
		fp_rs1 = 1'b0;
		fp_rs2 = 1'b0;
		fp_rd = 1'b0;
		case (opcode)
			`FETCH_OP_OP, `FETCH_OP_OP_FP: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				use_rd = 1'b1;
				if (opcode == `FETCH_OP_OP_FP) begin
					fp_rs2 = 1'b1;
					fp_rs1 = !fmv_x_w && (funct7 != `FETCH_F7_FMV_W_X) &&
						(funct7 != `FETCH_F7_FCVT_S_W);
					fp_rd = !fmv_x_w && (funct7 != `FETCH_F7_FCVT_W_S) &&
						(funct7 != `FETCH_F7_FCMP);
				end
			end
			`FETCH_OP_LOAD, `FETCH_OP_LOAD_FP, `FETCH_OP_OP_IMM, `FETCH_OP_JALR: begin
				use_rs1 = 1'b1;
				use_rd = 1'b1;
				fp_rd = (opcode == `FETCH_OP_LOAD_FP);
			end
			`FETCH_OP_STORE, `FETCH_OP_STORE_FP, `FETCH_OP_BRANCH: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				fp_rs2 = (opcode == `FETCH_OP_STORE_FP);
			end
			`FETCH_OP_JAL, `FETCH_OP_LUI, `FETCH_OP_AUIPC: begin
				use_rd = 1'b1;
			end
			`FETCH_OP_SYSTEM: begin
				use_rs1 = (funct3 != 3'b000);
				use_rd = (funct3 != 3'b000);
			end
			default: begin
			end
		endcase
		rs1 = use_rs1 ? {fp_rs1, insn[19:15]} : 6'd0;
		rs2 = use_rs2 ? {fp_rs2, insn[24:20]} : 6'd0;
		rd = use_rd ? {fp_rd, insn[11:7]} : 6'd0;
	endfunction

	task automatic load_program;
		logic [7:0] idx;
		// ADDI filler; every field comes from the word address
		for (int i = 0; i < 256; i++) begin
			idx = i[7:0];
			mem[i] = {4'h0, idx, idx[4:0], 3'b000, idx[7:3], `FETCH_OP_OP_IMM};
		end
		mem[0] = encode_i(12'd5, 5'd0, 3'b000, 5'd1, `FETCH_OP_OP_IMM);
		mem[1] = encode_r(7'd0, 5'd2, 5'd1, 3'b000, 5'd3, `FETCH_OP_OP);
		// FLW f2 and FSW f2
		mem[2] = encode_i(12'd8, 5'd1, 3'b010, 5'd2, `FETCH_OP_LOAD_FP);
		mem[3] = encode_s(12'd4, 5'd2, 5'd3, 3'b010, `FETCH_OP_STORE_FP);
		// FADD.S, FEQ.S, FMV.X.W
		mem[4] = encode_r(7'd0, 5'd3, 5'd2, 3'b000, 5'd4, `FETCH_OP_OP_FP);
		mem[5] = encode_r(`FETCH_F7_FCMP, 5'd2, 5'd4, 3'b010, 5'd5, `FETCH_OP_OP_FP);
		mem[6] = encode_r(`FETCH_F7_FMV_X_W, 5'd0, 5'd4, 3'b000, 5'd6, `FETCH_OP_OP_FP);
		mem[7] = {20'h12345, 5'd7, `FETCH_OP_LUI};
		mem[8] = encode_s(12'd0, 5'd7, 5'd1, 3'b010, `FETCH_OP_STORE);
		mem[9] = encode_b(13'd16, 5'd2, 5'd1, 3'b000);
		// Jump targets placed on lines 10 to 14 to keep lines 0 to 9 cached
		mem[26] = encode_i(12'd1, 5'd1, 3'b000, 5'd1, `FETCH_OP_OP_IMM);
		mem[27] = {20'h00100, 5'd1, `FETCH_OP_JAL};
		mem[30] = `FETCH_INSN_ECALL;
		mem[76] = encode_b(13'd8, 5'd4, 5'd3, 3'b001);
		mem[130] = encode_i(12'd0, 5'd1, 3'b000, 5'd0, `FETCH_OP_JALR);
	endtask

	// Waits for the next tag and checks the whole bundle
	task automatic expect_bundle(input word_t expected_pc);
		int waited;
		word_t expected_insn;
		reg_index_t exp_rs1;
		reg_index_t exp_rs2;
		reg_index_t exp_rd;
		waited = 0;
		@(negedge i_clock);
		while (o_tag == last_tag) begin
			waited++;
			if (waited > BUNDLE_TIMEOUT) begin
				$display("Timeout: no new bundle arrived for pc %h", expected_pc);
				abort_run();
			end
			@(negedge i_clock);
		end
		expected_insn = mem[expected_pc[9:2]];
		predict_indices(expected_insn, exp_rs1, exp_rs2, exp_rd);
		compare_tag("o_tag", o_tag, last_tag + 8'd1);
		compare_word("o_pc", o_pc, expected_pc);
		compare_word("o_instruction", o_instruction, expected_insn);
		compare_index("o_rs1", o_rs1, exp_rs1);
		compare_index("o_rs2", o_rs2, exp_rs2);
		compare_index("o_rs3", o_rs3, 6'd0);
		compare_index("o_rd", o_rd, exp_rd);
		last_tag = o_tag;
		last_pc = o_pc;
	endtask

	task automatic check_no_new_tag(input int cycles);
		repeat (cycles) begin
			@(negedge i_clock);
			compare_tag("o_tag while stopped", o_tag, last_tag);
		end
	endtask

	task automatic send_jump(input word_t target);
		@(negedge i_clock);
		i_jump = 1'b1;
		i_jump_pc = target;
		@(negedge i_clock);
		i_jump = 1'b0;
	endtask

	task automatic test_reset_state;
		@(negedge i_clock);
		compare_flag("o_bus_request", o_bus_request, 1'b0);
		compare_flag("o_irq_dispatched", o_irq_dispatched, 1'b0);
		compare_word("o_irq_epc", o_irq_epc, 32'd0);
		compare_tag("o_tag", o_tag, 8'd0);
		compare_word("o_pc", o_pc, 32'd0);
		compare_word("o_instruction", o_instruction, 32'd0);
		compare_index("o_rs1", o_rs1, 6'd0);
		compare_index("o_rs2", o_rs2, 6'd0);
		compare_index("o_rs3", o_rs3, 6'd0);
		compare_index("o_rd", o_rd, 6'd0);
		i_reset = 1'b0;
		last_tag = 8'd0;
		last_pc = 32'd0;
	endtask

	task automatic test_sequential_fetch;
		expect_bundle(`FETCH_RESET_VECTOR);
		// Ends on the branch at 0x24
		repeat (9) expect_bundle(last_pc + 32'd4);
	endtask

	task automatic test_control_flow_stop;
		check_no_new_tag(20);
		send_jump(32'h68);
		expect_bundle(32'h68);
		expect_bundle(32'h6C);
		check_no_new_tag(20);
		send_jump(32'h78);
		expect_bundle(32'h78);
		check_no_new_tag(20);
	endtask

	task automatic test_cache_hits;
		int start_count;
		start_count = bus_request_count;
		send_jump(32'h00);
		expect_bundle(32'h00);
		repeat (9) expect_bundle(last_pc + 32'd4);
		if (bus_request_count != start_count) begin
			$display("ERROR at %0t: %0d bus requests on cached code, expected none",
				$time, bus_request_count - start_count);
			abort_run();
		end
	endtask

	task automatic test_back_pressure;
		int busy_cycles;
		int waited;
		fetch_tag_t snap_tag;
		word_t snap_pc;
		word_t snap_insn;
		reg_index_t snap_rs1;
		reg_index_t snap_rs2;
		reg_index_t snap_rd;
		send_jump(32'h100);
		expect_bundle(32'h100);
		expect_bundle(32'h104);
		// Line 2 still holds 0x08, so 0x108 goes to memory
		@(negedge i_clock);
		compare_flag("o_bus_request on miss", o_bus_request, 1'b1);
		waited = 0;
		while (o_bus_request) begin
			waited++;
			if (waited > BUNDLE_TIMEOUT) begin
				$display("Timeout: memory never answered the refill for pc 108");
				abort_run();
			end
			@(negedge i_clock);
		end
		// Refilled word is presented now and the sequencer takes it under busy
		compare_tag("o_tag before busy", o_tag, last_tag);
		snap_tag = o_tag;
		snap_pc = o_pc;
		snap_insn = o_instruction;
		snap_rs1 = o_rs1;
		snap_rs2 = o_rs2;
		snap_rd = o_rd;
		i_decode_busy = 1'b1;
		busy_cycles = 3 + ({$random(seed)} % 8);
		repeat (busy_cycles) begin
			@(negedge i_clock);
			compare_tag("held o_tag", o_tag, snap_tag);
			compare_word("held o_pc", o_pc, snap_pc);
			compare_word("held o_instruction", o_instruction, snap_insn);
			compare_index("held o_rs1", o_rs1, snap_rs1);
			compare_index("held o_rs2", o_rs2, snap_rs2);
			compare_index("held o_rd", o_rd, snap_rd);
		end
		i_decode_busy = 1'b0;
		repeat (3) expect_bundle(last_pc + 32'd4);
	endtask

	task automatic test_interrupt;
		// Run up to the branch at 0x130
		while (last_pc != 32'h130) begin
			expect_bundle(last_pc + 32'd4);
		end
		repeat (4) @(negedge i_clock);
		i_irq_pc = 32'h200;
		i_irq_pending = 1'b1;
		@(negedge i_clock);
		compare_flag("o_irq_dispatched", o_irq_dispatched, 1'b1);
		compare_word("o_irq_epc", o_irq_epc, 32'h130);
		i_irq_pending = 1'b0;
		// Not waiting for a jump now, so this one is dropped
		i_jump = 1'b1;
		i_jump_pc = 32'h300;
		@(negedge i_clock);
		i_jump = 1'b0;
		compare_flag("o_irq_dispatched after pulse", o_irq_dispatched, 1'b0);
		expect_bundle(32'h200);
		expect_bundle(32'h204);
		expect_bundle(32'h208);
		check_no_new_tag(10);
		send_jump(32'h300);
		expect_bundle(32'h300);
	endtask

	initial begin
		i_reset = 1'b1;
		i_jump = 1'b0;
		i_jump_pc = '0;
		i_irq_pending = 1'b0;
		i_irq_pc = '0;
		i_bus_ready = 1'b0;
		i_bus_rdata = '0;
		i_decode_busy = 1'b0;
		seed = 32'h4841_da2e;
		load_program();
		repeat (8) @(posedge i_clock);
		test_reset_state();
		test_sequential_fetch();
		test_control_flow_stop();
		test_cache_hits();
		test_back_pressure();
		test_interrupt();
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_predecode.sv
verilog/fetch_icache.sv
verilog/fetch_hold_buffer.sv
verilog/fetch_sequencer.sv
verilog/fetch_top.sv
testbench/fetch_tb.sv

// File: Makefile
# Verilator build and run of the fetch stage testbench

SIM = obj_dir/fetch_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module fetch_tb -f project.f -o fetch_sim

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir
